// File: ad7124_rtd_pkg.sv
`default_nettype none

package ad7124_rtd_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int SAMPLE_W    = 32;
    localparam int BYTE_W      = 8;
    // command byte, 3 data bytes, appended status byte
    localparam int FRAME_BYTES = 5;
    localparam int BUF_ADDR_W  = 4;

    // communications register commands
    typedef enum logic [BYTE_W-1:0] {
        CMD_READ_DATA = 8'h42,
        CMD_NOP       = 8'hFF
    } ad7124_cmd_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_CMD   = 2'd1,
        SEQ_READ  = 2'd2,
        SEQ_STORE = 2'd3
    } seq_state_e;

    // ----------------------------------------------------------------------
    // bundles between blocks
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

    typedef struct packed {
        logic              start;
        logic [BYTE_W-1:0] tx_data;
    } byte_req_t;

    typedef struct packed {
        logic              done;
        logic [BYTE_W-1:0] rx_data;
    } byte_rsp_t;

    // data: conversion result in [31:8], status byte in [7:0]
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] data;
    } sample_wr_t;

endpackage

`default_nettype wire

// File: ad7124_drdy_detect.sv
`timescale 1ns/100ps
`default_nettype none

module ad7124_drdy_detect (
    input  wire  spi_clk_i,
    input  wire  rst_n_i,
    input  wire  miso_i,
    input  wire  active_i,
    input  wire  cs_n_i,
    output logic trigger_o
);

    // DOUT/RDY after the two synchronizer stages
    logic [1:0] sync_q;
    // synced level one cycle earlier
    logic       prev_q;
    logic       trigger_q;

    // DOUT/RDY idles high, so reset the chain high to avoid a false edge
    always_ff @(posedge spi_clk_i) begin
        if (!rst_n_i) begin
            sync_q    <= 2'b11;
            prev_q    <= 1'b1;
            trigger_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], miso_i};
            prev_q <= sync_q[1];
            // high to low on DOUT/RDY means a conversion is ready
            // ignored while a frame is on the wire or CS is released
            trigger_q <= prev_q & ~sync_q[1] & ~cs_n_i & ~active_i;
        end
    end

    assign trigger_o = trigger_q;

endmodule

`default_nettype wire

// File: ad7124_read_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module ad7124_read_sequencer (
    input  wire                            spi_clk_i,
    input  wire                            rst_n_i,
    input  wire                            enable_i,
    output logic                           enabled_o,
    input  wire                            trigger_i,
    output logic                           active_o,
    output logic                           cs_n_o,
    output ad7124_rtd_pkg::byte_req_t      req_o,
    input  wire ad7124_rtd_pkg::byte_rsp_t rsp_i,
    input  wire                            busy_i,
    output ad7124_rtd_pkg::sample_wr_t     wr_o
);

    localparam int BW         = ad7124_rtd_pkg::BYTE_W;
    localparam int SW         = ad7124_rtd_pkg::SAMPLE_W;
    // bytes clocked in after the command byte
    localparam int READ_BYTES = ad7124_rtd_pkg::FRAME_BYTES - 1;
    localparam int CNT_W      = $clog2(READ_BYTES);

    ad7124_rtd_pkg::seq_state_e state_q;
    ad7124_rtd_pkg::byte_req_t  req_q;
    logic [CNT_W-1:0]           byte_cnt_q;
    logic [SW-1:0]              sample_q;
    logic                       enabled_q;
    logic                       cs_n_q;
    logic                       byte_done;
    logic                       last_byte;

    assign byte_done = rsp_i.done && !busy_i;
    assign last_byte = (byte_cnt_q == CNT_W'(READ_BYTES - 1));

    // ----------------------------------------------------------------------
    // frame FSM and enable tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge spi_clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ad7124_rtd_pkg::SEQ_IDLE;
            req_q      <= '0;
            byte_cnt_q <= '0;
            enabled_q  <= 1'b0;
            cs_n_q     <= 1'b1;
        end else begin
            req_q.start <= 1'b0;
            case (state_q)
                ad7124_rtd_pkg::SEQ_IDLE: begin
                    if (trigger_i && enabled_q && !busy_i) begin
                        req_q.start   <= 1'b1;
                        req_q.tx_data <= ad7124_rtd_pkg::CMD_READ_DATA;
                        byte_cnt_q    <= '0;
                        state_q       <= ad7124_rtd_pkg::SEQ_CMD;
                    end else begin
                        // enable only moves between frames
                        enabled_q <= enable_i;
                        cs_n_q    <= ~enable_i;
                    end
                end
                ad7124_rtd_pkg::SEQ_CMD: begin
                    if (byte_done) begin
                        req_q.start   <= 1'b1;
                        req_q.tx_data <= ad7124_rtd_pkg::CMD_NOP;
                        state_q       <= ad7124_rtd_pkg::SEQ_READ;
                    end
                end
                ad7124_rtd_pkg::SEQ_READ: begin
                    if (byte_done) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (last_byte) begin
                            state_q <= ad7124_rtd_pkg::SEQ_STORE;
                        end else begin
                            req_q.start   <= 1'b1;
                            req_q.tx_data <= ad7124_rtd_pkg::CMD_NOP;
                        end
                    end
                end
                ad7124_rtd_pkg::SEQ_STORE: begin
                    state_q <= ad7124_rtd_pkg::SEQ_IDLE;
                end
                default: begin
                    state_q <= ad7124_rtd_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // data bytes arrive MSB first, status byte lands at the bottom
    always_ff @(posedge spi_clk_i) begin
        if (state_q == ad7124_rtd_pkg::SEQ_READ && byte_done) begin
            sample_q <= {sample_q[SW-BW-1:0], rsp_i.rx_data};
        end
    end

    assign wr_o.valid = (state_q == ad7124_rtd_pkg::SEQ_STORE);
    assign wr_o.data  = sample_q;
    assign active_o   = (state_q != ad7124_rtd_pkg::SEQ_IDLE);
    assign enabled_o  = enabled_q;
    assign cs_n_o     = cs_n_q;
    assign req_o      = req_q;

endmodule

`default_nettype wire

// File: spi_byte_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module spi_byte_shifter #(
    parameter logic [7:0] CLK_DIV = 8'd24
) (
    input  wire                            spi_clk_i,
    input  wire                            rst_n_i,
    input  wire ad7124_rtd_pkg::byte_req_t req_i,
    output ad7124_rtd_pkg::byte_rsp_t      rsp_o,
    output logic                           busy_o,
    input  wire                            miso_i,
    output logic                           sclk_o,
    output logic                           mosi_o
);

    localparam int BW        = ad7124_rtd_pkg::BYTE_W;
    // two SCLK half periods per bit
    localparam int HALF_W    = $clog2(2 * BW);
    localparam int HALF_LAST = 2 * BW - 1;

    logic [7:0]        div_cnt_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic              busy_q;
    logic              done_q;
    logic              sclk_q;
    logic              mosi_q;
    logic [BW-1:0]     tx_sr_q;
    logic [BW-1:0]     rx_sr_q;
    logic              tick;
    logic              last_half;

    // end of one SCLK half period
    assign tick      = busy_q && (div_cnt_q == CLK_DIV);
    assign last_half = (half_cnt_q == HALF_W'(HALF_LAST));

    // ----------------------------------------------------------------------
    // SCLK divider and byte control, mode 3
    // ----------------------------------------------------------------------
    always_ff @(posedge spi_clk_i) begin
        if (!rst_n_i) begin
            div_cnt_q  <= '0;
            half_cnt_q <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            sclk_q     <= 1'b1;
            mosi_q     <= 1'b1;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (req_i.start) begin
                    // first falling edge right away, MSB goes out with it
                    busy_q     <= 1'b1;
                    div_cnt_q  <= '0;
                    half_cnt_q <= '0;
                    sclk_q     <= 1'b0;
                    mosi_q     <= req_i.tx_data[BW-1];
                end
            end else if (tick) begin
                div_cnt_q  <= '0;
                half_cnt_q <= half_cnt_q + 1'b1;
                if (last_half) begin
                    // SCLK already high, back to idle
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    mosi_q <= 1'b1;
                end else begin
                    sclk_q <= ~sclk_q;
                    if (sclk_q) begin
                        mosi_q <= tx_sr_q[BW-1];
                    end
                end
            end else begin
                div_cnt_q <= div_cnt_q + 8'd1;
            end
        end
    end

    // shift registers
    always_ff @(posedge spi_clk_i) begin
        if (!busy_q && req_i.start) begin
            tx_sr_q <= {req_i.tx_data[BW-2:0], 1'b1};
        end else if (tick && sclk_q && !last_half) begin
            tx_sr_q <= {tx_sr_q[BW-2:0], 1'b1};
        end
        // sample on the rising edge
        if (tick && !sclk_q) begin
            rx_sr_q <= {rx_sr_q[BW-2:0], miso_i};
        end
    end

    assign rsp_o.done    = done_q;
    assign rsp_o.rx_data = rx_sr_q;
    assign busy_o        = busy_q;
    assign sclk_o        = sclk_q;
    assign mosi_o        = mosi_q;

endmodule

`default_nettype wire

// File: ad7124_sample_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ad7124_sample_buffer (
    input  wire                                    spi_clk_i,
    input  wire                                    rst_n_i,
    input  wire ad7124_rtd_pkg::sample_wr_t        wr_i,
    input  wire                                    bram_en_i,
    input  wire [ad7124_rtd_pkg::BUF_ADDR_W-1:0]   bram_addr_i,
    output logic [ad7124_rtd_pkg::SAMPLE_W-1:0]    bram_dout_o,
    output logic                                   drdy_o
);

    localparam int AW    = ad7124_rtd_pkg::BUF_ADDR_W;
    localparam int SW    = ad7124_rtd_pkg::SAMPLE_W;
    localparam int DEPTH = 2 ** AW;

    logic [SW-1:0] mem_q [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [SW-1:0] dout_q;
    logic          drdy_q;

    // ----------------------------------------------------------------------
    // write side, oldest word is overwritten
    // ----------------------------------------------------------------------
    always_ff @(posedge spi_clk_i) begin
        if (wr_i.valid) begin
            mem_q[wr_ptr_q] <= wr_i.data;
        end
    end

    always_ff @(posedge spi_clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            drdy_q   <= 1'b0;
        end else begin
            // pointer wraps on its own at DEPTH
            if (wr_i.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            // strobe lands once the word is readable
            drdy_q <= wr_i.valid;
        end
    end

    // registered read port, holds its value while bram_en_i is low
    always_ff @(posedge spi_clk_i) begin
        if (!rst_n_i) begin
            dout_q <= '0;
        end else if (bram_en_i) begin
            dout_q <= mem_q[bram_addr_i];
        end
    end

    assign bram_dout_o = dout_q;
    assign drdy_o      = drdy_q;

endmodule

`default_nettype wire

// File: ad7124_rtd_channel.sv
`timescale 1ns/100ps
`default_nettype none

module ad7124_rtd_channel #(
    // SCLK half period is CLK_DIV+1 clocks
    parameter logic [7:0] CLK_DIV = 8'd24
) (
    input  wire                                  spi_clk_i,
    input  wire                                  rst_n_i,
    input  wire                                  enable_i,
    output wire                                  enabled_o,
    // SPI pins
    output wire                                  sclk_o,
    output wire                                  cs_n_o,
    output wire                                  mosi_o,
    input  wire                                  miso_i,
    // sample read port
    input  wire                                  bram_en_i,
    input  wire [ad7124_rtd_pkg::BUF_ADDR_W-1:0] bram_addr_i,
    output wire [ad7124_rtd_pkg::SAMPLE_W-1:0]   bram_dout_o,
    output wire                                  drdy_o
);

    wire ad7124_rtd_pkg::spi_pins_t spi_pins;
    logic                           trigger;
    logic                           active;
    logic                           shifter_busy;
    ad7124_rtd_pkg::byte_req_t      byte_req;
    ad7124_rtd_pkg::byte_rsp_t      byte_rsp;
    ad7124_rtd_pkg::sample_wr_t     sample_wr;

    assign sclk_o = spi_pins.sclk;
    assign cs_n_o = spi_pins.cs_n;
    assign mosi_o = spi_pins.mosi;

    // DOUT/RDY falling edge starts the offload read
    ad7124_drdy_detect i_drdy_detect (
        .spi_clk_i(spi_clk_i    ),
        .rst_n_i  (rst_n_i      ),
        .miso_i   (miso_i       ),
        .active_i (active       ),
        .cs_n_i   (spi_pins.cs_n),
        .trigger_o(trigger      )
    );

    ad7124_read_sequencer i_read_sequencer (
        .spi_clk_i(spi_clk_i    ),
        .rst_n_i  (rst_n_i      ),
        .enable_i (enable_i     ),
        .enabled_o(enabled_o    ),
        .trigger_i(trigger      ),
        .active_o (active       ),
        .cs_n_o   (spi_pins.cs_n),
        .req_o    (byte_req     ),
        .rsp_i    (byte_rsp     ),
        .busy_i   (shifter_busy ),
        .wr_o     (sample_wr    )
    );

    spi_byte_shifter #(
        .CLK_DIV(CLK_DIV)
    ) i_byte_shifter (
        .spi_clk_i(spi_clk_i    ),
        .rst_n_i  (rst_n_i      ),
        .req_i    (byte_req     ),
        .rsp_o    (byte_rsp     ),
        .busy_o   (shifter_busy ),
        .miso_i   (miso_i       ),
        .sclk_o   (spi_pins.sclk),
        .mosi_o   (spi_pins.mosi)
    );

    ad7124_sample_buffer i_sample_buffer (
        .spi_clk_i  (spi_clk_i  ),
        .rst_n_i    (rst_n_i    ),
        .wr_i       (sample_wr  ),
        .bram_en_i  (bram_en_i  ),
        .bram_addr_i(bram_addr_i),
        .bram_dout_o(bram_dout_o),
        .drdy_o     (drdy_o     )
    );

endmodule

`default_nettype wire

// File: ad7124_adc_model.sv
`timescale 1ns/100ps
`default_nettype none

module ad7124_adc_model (
    input  wire         clk_i,
    input  wire         rst_n_i,
    input  wire         sclk_i,
    input  wire         cs_n_i,
    input  wire         mosi_i,
    // level, a rising edge marks a finished conversion
    input  wire         conv_i,
    input  wire  [31:0] sample_i,
    output logic        dout_o,
    // last 40 MOSI bits, first byte in the top bits
    output logic [39:0] mosi_frame_o,
    // all rising SCLK edges since reset
    output int          rises_o,
    output logic        cs_glitch_o
);

    logic        sclk_q;
    logic        conv_q;
    logic        in_frame_q;
    logic [31:0] data_sr_q;
    int          falls_q;
    int          frame_rises_q;
    logic        sclk_fall;
    logic        sclk_rise;

    // SCLK edges seen on the system clock
    assign sclk_fall = sclk_q && !sclk_i;
    assign sclk_rise = !sclk_q && sclk_i;

    // ----------------------------------------------------------------------
    // DOUT/RDY and frame tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sclk_q        <= 1'b1;
            conv_q        <= 1'b0;
            in_frame_q    <= 1'b0;
            data_sr_q     <= '0;
            falls_q       <= 0;
            frame_rises_q <= 0;
            dout_o        <= 1'b1;
            mosi_frame_o  <= '0;
            rises_o       <= 0;
            cs_glitch_o   <= 1'b0;
        end else begin
            sclk_q <= sclk_i;
            conv_q <= conv_i;
            if (conv_i && !conv_q) begin
                // conversion ready, DOUT/RDY goes low
                dout_o        <= 1'b0;
                in_frame_q    <= 1'b1;
                data_sr_q     <= sample_i;
                falls_q       <= 0;
                frame_rises_q <= 0;
                cs_glitch_o   <= 1'b0;
            end else if (!conv_i && conv_q) begin
                dout_o     <= 1'b1;
                in_frame_q <= 1'b0;
            end else if (in_frame_q) begin
                if (sclk_fall) begin
                    falls_q <= falls_q + 1;
                    // command byte is done after 8 falling edges
                    if (falls_q >= 8) begin
                        dout_o    <= data_sr_q[31];
                        data_sr_q <= {data_sr_q[30:0], 1'b1};
                    end
                end
                if (sclk_rise) begin
                    mosi_frame_o  <= {mosi_frame_o[38:0], mosi_i};
                    frame_rises_q <= frame_rises_q + 1;
                    if (frame_rises_q == 39) begin
                        // last bit taken, release DOUT/RDY
                        dout_o     <= 1'b1;
                        in_frame_q <= 1'b0;
                    end
                end
                // CS must not rise once the frame has started
                if (cs_n_i && falls_q != 0) begin
                    cs_glitch_o <= 1'b1;
                end
            end
            if (sclk_rise) begin
                rises_o <= rises_o + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_ad7124_rtd_channel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ad7124_rtd_channel;

    localparam int FRAMES   = 20;
    localparam int DEPTH    = 2 ** ad7124_rtd_pkg::BUF_ADDR_W;
    localparam int FRAME_TO = 2000;
    // read-data command, then four NOP bytes
    localparam logic [39:0] EXP_MOSI = {8'h42, 32'hFFFF_FFFF};

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        enabled;
    logic        sclk;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic        bram_en;
    logic [3:0]  bram_addr;
    logic [31:0] bram_dout;
    logic        drdy;
    logic        conv;
    logic [31:0] conv_sample;
    logic [39:0] mosi_frame;
    int          sclk_rises;
    logic        cs_glitch;

    logic [31:0] lcg_state;
    logic [31:0] samples [FRAMES+1];
    int          errors;
    int          assert_errors;
    int          tests_run;
    int          tests_failed;

    ad7124_rtd_channel #(
        .CLK_DIV(8'd2)
    ) dut (
        .spi_clk_i  (clk      ),
        .rst_n_i    (rst_n    ),
        .enable_i   (enable   ),
        .enabled_o  (enabled  ),
        .sclk_o     (sclk     ),
        .cs_n_o     (cs_n     ),
        .mosi_o     (mosi     ),
        .miso_i     (miso     ),
        .bram_en_i  (bram_en  ),
        .bram_addr_i(bram_addr),
        .bram_dout_o(bram_dout),
        .drdy_o     (drdy     )
    );

    ad7124_adc_model adc (
        .clk_i       (clk        ),
        .rst_n_i     (rst_n      ),
        .sclk_i      (sclk       ),
        .cs_n_i      (cs_n       ),
        .mosi_i      (mosi       ),
        .conv_i      (conv       ),
        .sample_i    (conv_sample),
        .dout_o      (miso       ),
        .mosi_frame_o(mosi_frame ),
        .rises_o     (sclk_rises ),
        .cs_glitch_o (cs_glitch  )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // bus rules checked on every clock
    // ----------------------------------------------------------------------
    idle_pins: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> (sclk && mosi))
        else begin
            assert_errors = assert_errors + 1;
            $display("%0t: SCLK or MOSI not idle high while CS is released", $time);
        end

    drdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) drdy |-> !$past(drdy))
        else begin
            assert_errors = assert_errors + 1;
            $display("%0t: drdy_o stayed high for more than one cycle", $time);
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
            else begin
                errors = errors + 1;
                $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            end
    endtask

    task automatic fail(input string what);
        errors = errors + 1;
        $display("%0t: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int fails);
        tests_run = tests_run + 1;
        if (fails == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: %0d failed checks", tests_run, name, fails);
        end
    endtask

    task automatic wait_drdy();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < FRAME_TO && !seen; i++) begin
            @(negedge clk);
            seen = drdy;
        end
        if (!seen) begin
            fail("timeout waiting for drdy_o");
        end
    endtask

    task automatic wait_rises(input int count, input int start);
        bit reached;
        reached = 1'b0;
        for (int i = 0; i < FRAME_TO && !reached; i++) begin
            @(negedge clk);
            reached = (sclk_rises - start >= count);
        end
        if (!reached) begin
            fail("timeout waiting for SCLK edges");
        end
    endtask

    task automatic wait_enabled(input logic level);
        bit reached;
        reached = 1'b0;
        for (int i = 0; i < 20 && !reached; i++) begin
            @(negedge clk);
            reached = (enabled == level);
        end
        if (!reached) begin
            fail("timeout waiting for enabled_o to follow enable_i");
        end
    endtask

    // no drdy_o and no SCLK edge may show up for a while
    task automatic expect_quiet(input int cycles);
        int  rises_start;
        bit  quiet;
        rises_start = sclk_rises;
        quiet = 1'b1;
        for (int i = 0; i < cycles && quiet; i++) begin
            @(negedge clk);
            if (drdy || sclk_rises != rises_start) begin
                quiet = 1'b0;
                fail("SPI activity while the channel is disabled");
            end
        end
    endtask

    task automatic start_conversion(input logic [31:0] smp);
        @(negedge clk);
        conv_sample = smp;
        conv        = 1'b1;
    endtask

    task automatic finish_conversion();
        conv = 1'b0;
        repeat (6) @(negedge clk);
    endtask

    task automatic read_word(input int addr, output logic [31:0] word);
        @(negedge clk);
        bram_en   = 1'b1;
        bram_addr = 4'(addr);
        @(negedge clk);
        bram_en = 1'b0;
        word    = bram_dout;
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        int          e0;
        int          fails3;
        int          fails4;
        int          rises0;
        int          exp_idx;
        logic [31:0] word;

        rst_n         = 1'b0;
        enable        = 1'b0;
        bram_en       = 1'b0;
        bram_addr     = '0;
        conv          = 1'b0;
        conv_sample   = '0;
        errors        = 0;
        assert_errors = 0;
        tests_run     = 0;
        tests_failed  = 0;
        fails3        = 0;
        fails4        = 0;
        lcg_state     = 32'hd2405776;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        e0 = errors;
        compare("cs_n_o", 64'(cs_n), 64'(1'b1));
        compare("sclk_o", 64'(sclk), 64'(1'b1));
        compare("mosi_o", 64'(mosi), 64'(1'b1));
        compare("enabled_o", 64'(enabled), 64'(1'b0));
        compare("drdy_o", 64'(drdy), 64'(1'b0));
        compare("bram_dout_o", 64'(bram_dout), 64'(0));
        report_test("reset state", errors - e0);

        // DOUT/RDY edge while disabled must be ignored
        e0 = errors;
        start_conversion(32'h0);
        expect_quiet(200);
        finish_conversion();
        enable = 1'b1;
        wait_enabled(1'b1);
        compare("cs_n_o", 64'(cs_n), 64'(1'b0));
        report_test("enable control", errors - e0);

        for (int n = 0; n < FRAMES; n++) begin
            lcg_state  = lcg_next(lcg_state);
            samples[n] = lcg_state;
            rises0     = sclk_rises;
            start_conversion(samples[n]);
            e0 = errors;
            wait_drdy();
            read_word(n % DEPTH, word);
            compare("bram_dout_o", 64'(word), 64'(samples[n]));
            fails4 = fails4 + errors - e0;
            e0 = errors;
            compare("mosi bytes", 64'(mosi_frame), 64'(EXP_MOSI));
            compare("sclk rising edges", 64'(sclk_rises - rises0), 64'(40));
            compare("cs_n_o high in frame", 64'(cs_glitch), 64'(1'b0));
            fails3 = fails3 + errors - e0;
            finish_conversion();
        end
        report_test("command byte", fails3);
        report_test("sample capture", fails4);

        // oldest four frames were overwritten
        e0 = errors;
        for (int a = 0; a < DEPTH; a++) begin
            exp_idx = (a < FRAMES - DEPTH) ? a + DEPTH : a;
            read_word(a, word);
            compare("bram_dout_o", 64'(word), 64'(samples[exp_idx]));
        end
        report_test("buffer wrap", errors - e0);

        e0 = errors;
        lcg_state       = lcg_next(lcg_state);
        samples[FRAMES] = lcg_state;
        rises0          = sclk_rises;
        start_conversion(samples[FRAMES]);
        wait_rises(12, rises0);
        enable = 1'b0;
        wait_drdy();
        read_word(FRAMES % DEPTH, word);
        compare("bram_dout_o", 64'(word), 64'(samples[FRAMES]));
        compare("sclk rising edges", 64'(sclk_rises - rises0), 64'(40));
        compare("cs_n_o high in frame", 64'(cs_glitch), 64'(1'b0));
        finish_conversion();
        wait_enabled(1'b0);
        compare("cs_n_o", 64'(cs_n), 64'(1'b1));
        report_test("disable during a frame", errors - e0);

        $display("tests: %0d run, %0d failed, %0d check errors, %0d bus rule errors",
                 tests_run, tests_failed, errors, assert_errors);
        if (tests_failed == 0 && errors == 0 && assert_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ad7124_rtd_channel.f
ad7124_rtd_pkg.sv
ad7124_drdy_detect.sv
ad7124_read_sequencer.sv
spi_byte_shifter.sv
ad7124_sample_buffer.sv
ad7124_rtd_channel.sv
ad7124_adc_model.sv
tb_ad7124_rtd_channel.sv

// File: Makefile
TOP := tb_ad7124_rtd_channel

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f ad7124_rtd_channel.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
